/* all.f */
design/lsu_pkg.sv
design/apb_mem_front.sv
design/mem_access_decode.sv
design/mem_bank.sv
design/load_extract.sv
design/mem_subsys.sv
verif/tb_mem_subsys.sv

/* design/apb_mem_front.sv */
// APB slave front end; handles one transfer at a time, pready comes 4 cycles into the access phase
`timescale 1ns/10ps

module apb_mem_front import lsu_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [ADDR_W-1:0] paddr,
    input  logic [DATA_W-1:0] pwdata,
    output logic [DATA_W-1:0] prdata,
    output logic              pready,
    output logic              pslverr,
    output mem_req_t          req,
    input  mem_rsp_t          rsp
);

    front_state_e      state;
    logic [DATA_W-1:0] rdata_q;
    logic              err_q;

    // state machine, request launch and payload capture
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ST_IDLE;
            req   <= '0;
        end else begin
            req.valid <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (psel && penable) begin
                        req.valid <= 1'b1;
                        req.write <= pwrite;
                        req.addr  <= paddr;
                        req.wdata <= pwdata;
                        state     <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (rsp.valid) begin
                        state <= ST_DONE;
                    end
                end
                ST_DONE: begin
                    state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // hold the response until the done cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            err_q <= 1'b0;
        end else if (state == ST_WAIT && rsp.valid) begin
            err_q <= rsp.err;
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_WAIT && rsp.valid) begin
            rdata_q <= rsp.rdata;
        end
    end

    assign pready  = (state == ST_DONE);
    assign pslverr = pready & err_q;
    assign prdata  = rdata_q;

    a_pready_in_access: assert property (@(posedge clk) disable iff (!arst_n)
        pready |-> psel && penable);

    // the pipeline only answers a launched request
    a_rsp_in_wait: assert property (@(posedge clk) disable iff (!arst_n)
        rsp.valid |-> state == ST_WAIT);

endmodule

/* design/load_extract.sv */
// load extract stage; results are zero-extended, no sign extension
`timescale 1ns/10ps

module load_extract import lsu_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  bank_rsp_t bank,
    output mem_rsp_t  rsp
);

    logic [DATA_W-1:0] shifted;
    logic [DATA_W-1:0] masked;

    // bring the addressed lane down to byte 0
    assign shifted = bank.word >> {bank.lane, 3'b000};

    always_comb begin
        case (bank.width)
            W8: begin
                masked = {{(DATA_W-8){1'b0}}, shifted[7:0]};
            end
            W16: begin
                masked = {{(DATA_W-16){1'b0}}, shifted[15:0]};
            end
            W32: begin
                masked = {{(DATA_W-32){1'b0}}, shifted[31:0]};
            end
            default: begin
                masked = shifted;
            end
        endcase
    end

    // erroring access reads back as zero
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp <= '0;
        end else begin
            rsp.valid <= bank.valid;
            if (bank.valid) begin
                rsp.err   <= bank.err;
                rsp.rdata <= bank.err ? '0 : masked;
            end
        end
    end

endmodule

/* design/lsu_pkg.sv */
// shared types for the data-memory subsystem; one transfer in flight, widths fixed at 64-bit data
package lsu_pkg;

    // bus and storage geometry
    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 64;
    localparam int MEM_WORDS  = 256;
    localparam int WORD_IDX_W = 8;
    localparam int LANE_W     = 3;

    // access width, taken from paddr[13:12]
    typedef enum logic [1:0] {
        W8  = 2'd0,
        W16 = 2'd1,
        W32 = 2'd2,
        W64 = 2'd3
    } mem_width_e;

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_WAIT = 2'd1,
        ST_DONE = 2'd2
    } front_state_e;

    // front end to decode
    typedef struct packed {
        logic              valid;
        logic              write;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } mem_req_t;

    // decode to bank, store data already sits in its lanes
    typedef struct packed {
        logic                  valid;
        logic                  write;
        logic                  err;
        mem_width_e            width;
        logic [WORD_IDX_W-1:0] word_idx;
        logic [LANE_W-1:0]     lane;
        logic [DATA_W/8-1:0]   byte_en;
        logic [DATA_W-1:0]     wdata;
    } mem_op_t;

    typedef struct packed {
        logic              valid;
        logic              err;
        mem_width_e        width;
        logic [LANE_W-1:0] lane;
        logic [DATA_W-1:0] word;
    } bank_rsp_t;

    typedef struct packed {
        logic              valid;
        logic              err;
        logic [DATA_W-1:0] rdata;
    } mem_rsp_t;

endpackage

/* design/mem_access_decode.sv */
// decode stage; width comes from addr[13:12], addr[11] and addr[31:14] are ignored and alias
`timescale 1ns/10ps

module mem_access_decode import lsu_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  mem_req_t req,
    output mem_op_t  op
);

    mem_width_e            width;
    logic [WORD_IDX_W-1:0] word_idx;
    logic [LANE_W-1:0]     lane;
    logic                  err;
    logic [DATA_W/8-1:0]   base_en;
    logic [DATA_W/8-1:0]   byte_en;
    logic [DATA_W-1:0]     wdata_sh;

    assign width    = mem_width_e'(req.addr[13:12]);
    assign word_idx = req.addr[WORD_IDX_W+LANE_W-1:LANE_W];
    assign lane     = req.addr[LANE_W-1:0];

    // alignment check and lane mask per width
    always_comb begin
        case (width)
            W8: begin
                err     = 1'b0;
                base_en = 8'h01;
            end
            W16: begin
                err     = lane[0];
                base_en = 8'h03;
            end
            W32: begin
                err     = |lane[1:0];
                base_en = 8'h0f;
            end
            default: begin
                err     = |lane;
                base_en = 8'hff;
            end
        endcase
    end

    // no lanes on a read or a misaligned access
    assign byte_en  = (req.write && !err) ? (base_en << lane) : '0;
    assign wdata_sh = req.wdata << {lane, 3'b000};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            op <= '0;
        end else begin
            op.valid <= req.valid;
            if (req.valid) begin
                op.write    <= req.write;
                op.err      <= err;
                op.width    <= width;
                op.word_idx <= word_idx;
                op.lane     <= lane;
                op.byte_en  <= byte_en;
                op.wdata    <= wdata_sh;
            end
        end
    end

    // an aligned store keeps all of its lanes inside the word
    a_write_has_lanes: assert property (@(posedge clk) disable iff (!arst_n)
        op.valid && op.write && !op.err |-> $countones(op.byte_en) == (1 << op.width));

endmodule

/* design/mem_bank.sv */
// byte-enabled word RAM; contents are undefined until written, read is registered
`timescale 1ns/10ps

module mem_bank import lsu_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  mem_op_t   op,
    output bank_rsp_t rsp
);

    logic [DATA_W-1:0] mem [MEM_WORDS];
    logic [DATA_W-1:0] merged;

    // old word with this op's lanes folded in
    always_comb begin
        merged = mem[op.word_idx];
        for (int b = 0; b < DATA_W/8; b++) begin
            if (op.byte_en[b]) begin
                merged[b*8 +: 8] = op.wdata[b*8 +: 8];
            end
        end
    end

    // per-byte store
    always_ff @(posedge clk) begin
        for (int b = 0; b < DATA_W/8; b++) begin
            if (op.valid && op.byte_en[b]) begin
                mem[op.word_idx][b*8 +: 8] <= op.wdata[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp <= '0;
        end else begin
            rsp.valid <= op.valid;
            if (op.valid) begin
                rsp.err   <= op.err;
                rsp.width <= op.width;
                rsp.lane  <= op.lane;
                rsp.word  <= merged;
            end
        end
    end

    // a misaligned store must not touch the array
    a_err_no_lanes: assert property (@(posedge clk) disable iff (!arst_n)
        op.valid && op.err |-> op.byte_en == '0);

endmodule

/* design/mem_subsys.sv */
// data-memory subsystem top; APB slave, 2 KiB storage, serial transfers only
`timescale 1ns/10ps

module mem_subsys import lsu_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [ADDR_W-1:0] paddr,
    input  logic [DATA_W-1:0] pwdata,
    output logic [DATA_W-1:0] prdata,
    output logic              pready,
    output logic              pslverr
);

    mem_req_t  req;
    mem_op_t   op;
    bank_rsp_t bank_rsp;
    mem_rsp_t  rsp;

    apb_mem_front u_front (
        .clk     (clk),
        .arst_n  (arst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .req     (req),
        .rsp     (rsp)
    );

    mem_access_decode u_decode (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (req),
        .op     (op)
    );

    mem_bank u_bank (
        .clk    (clk),
        .arst_n (arst_n),
        .op     (op),
        .rsp    (bank_rsp)
    );

    load_extract u_extract (
        .clk    (clk),
        .arst_n (arst_n),
        .bank   (bank_rsp),
        .rsp    (rsp)
    );

endmodule

/* run.sh */
#!/bin/sh
# build and run the mem_subsys testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_mem_subsys -f all.f

# keep the output visible even when the simulation stops on an error
output="$(./obj_dir/Vtb_mem_subsys 2>&1)" || true
echo "$output"

echo "$output" | grep -q '^>>> PASS$'

/* verif/tb_mem_subsys.sv */
// testbench for mem_subsys; every word is written first, so reads never see undefined memory
`timescale 1ns/10ps

module tb_mem_subsys import lsu_pkg::*; ();

    // first access cycle plus 4 wait cycles
    localparam int ACCESS_CYCLES = 5;
    localparam int TIMEOUT       = 50;

    logic              clk;
    logic              arst_n;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [ADDR_W-1:0] paddr;
    logic [DATA_W-1:0] pwdata;
    logic [DATA_W-1:0] prdata;
    logic              pready;
    logic              pslverr;

    // byte-wide reference of the 2 KiB array
    logic [7:0]        shadow [2048];
    logic [DATA_W-1:0] exp_rdata;
    logic              exp_err;
    logic              chk_rdata;
    int                lat_cnt;
    string             test_name;
    logic [31:0]       lcg_state;

    mem_subsys u_mem_subsys (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    // upper half first, the low bits of an LCG repeat after a few steps
    function automatic logic [31:0] rand32();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {lcg_state[15:0], lcg_state[31:16]};
    endfunction

    // alias_bits fill paddr[31:14] and paddr[11]
    function automatic logic [ADDR_W-1:0] make_addr(input mem_width_e w, input int word,
                                                    input int lane, input logic [18:0] alias_bits);
        return {alias_bits[18:1], 2'(w), alias_bits[0], 8'(word), 3'(lane)};
    endfunction

    task automatic apb_access(input logic wr, input logic [ADDR_W-1:0] addr,
                              input logic [DATA_W-1:0] data);
        int                nbytes;
        int                base;
        logic              err;
        logic [DATA_W-1:0] expv;
        nbytes = 1 << addr[13:12];
        base   = int'(addr[10:0]);
        err    = (int'(addr[2:0]) % nbytes) != 0;
        expv   = '0;
        if (!err) begin
            for (int i = 0; i < nbytes; i++) begin
                expv[i*8 +: 8] = shadow[base + i];
            end
        end
        exp_err   = err;
        exp_rdata = expv;
        chk_rdata = !wr && !err;
        lat_cnt   = 0;
        // setup phase, then access phase one cycle later
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #1;
        penable = 1'b1;
        while (!pready) begin
            if (lat_cnt == TIMEOUT) begin
                report_failure($sformatf("no pready within %0d cycles in test %s",
                                         TIMEOUT, test_name));
            end
            @(posedge clk);
            #1;
            lat_cnt++;
        end
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        if (wr && !err) begin
            for (int i = 0; i < nbytes; i++) begin
                shadow[base + i] = data[i*8 +: 8];
            end
        end
    endtask

    // also covers the reset period, when psel is low
    a_quiet_outside_access: assert property (@(posedge clk)
        !(psel && penable) |-> !pready && !pslverr)
        else report_failure("pready or pslverr high outside an APB access phase");

    a_pslverr: assert property (@(posedge clk) disable iff (!arst_n)
        pready |-> pslverr == exp_err)
        else report_failure($sformatf("FAILED %s expected pslverr %0b actual %0b",
                                      test_name, $sampled(exp_err), $sampled(pslverr)));

    a_prdata: assert property (@(posedge clk) disable iff (!arst_n)
        pready && chk_rdata |-> prdata == exp_rdata)
        else report_failure($sformatf("FAILED %s expected %h actual %h",
                                      test_name, $sampled(exp_rdata), $sampled(prdata)));

    a_latency: assert property (@(posedge clk) disable iff (!arst_n)
        pready |-> lat_cnt == ACCESS_CYCLES)
        else report_failure($sformatf("FAILED %s expected %0d access cycles actual %0d",
                                      test_name, ACCESS_CYCLES, $sampled(lat_cnt)));

    a_pready_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        pready |=> !pready)
        else report_failure("pready stayed high for more than one cycle");

    initial begin
        logic [31:0]       r;
        logic [ADDR_W-1:0] a;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        arst_n    = 1'b0;
        lcg_state = 32'd90;
        exp_err   = 1'b0;
        exp_rdata = '0;
        chk_rdata = 1'b0;
        lat_cnt   = 0;
        test_name = "reset";
        repeat (16) @(posedge clk);
        #1;
        arst_n = 1'b1;
        repeat (3) @(posedge clk);
        #1;

        test_name = "fill";
        for (int w = 0; w < MEM_WORDS; w++) begin
            apb_access(1'b1, make_addr(W64, w, 0, '0), {8{8'(w)}} ^ 64'h5a3c_96e1_0f87_d24b);
        end

        test_name = "dword_round_trip";
        apb_access(1'b1, make_addr(W64, 17, 0, '0), 64'hfeed_beef_0123_4567);
        apb_access(1'b0, make_addr(W64, 17, 0, '0), '0);

        test_name = "lane_merge";
        apb_access(1'b1, make_addr(W8, 40, 3, '0), 64'h0000_0000_0000_00a5);
        apb_access(1'b1, make_addr(W16, 40, 6, '0), 64'h0000_0000_0000_c3d2);
        apb_access(1'b1, make_addr(W32, 40, 0, '0), 64'h0000_0000_1122_3344);
        apb_access(1'b0, make_addr(W64, 40, 0, '0), '0);

        test_name = "zero_extend";
        for (int w = 0; w < 3; w++) begin
            for (int l = 0; l < 8; l += (1 << w)) begin
                apb_access(1'b0, make_addr(mem_width_e'(w), 40, l, '0), '0);
            end
        end

        test_name = "misaligned";
        apb_access(1'b1, make_addr(W16, 50, 1, '0), '1);
        apb_access(1'b1, make_addr(W32, 50, 2, '0), '1);
        apb_access(1'b1, make_addr(W64, 50, 4, '0), '1);
        apb_access(1'b0, make_addr(W64, 50, 0, '0), '0);
        apb_access(1'b0, make_addr(W32, 50, 6, '0), '0);

        // full random address, so width, lane and alias bits all vary
        test_name = "random";
        for (int n = 0; n < 200; n++) begin
            r = rand32();
            a = rand32();
            if (r[3:2] != 2'd0) begin
                a[2:0] = a[2:0] & ~3'((1 << a[13:12]) - 1);
            end
            apb_access(r[0], a, {rand32(), rand32()});
        end

        $display(">>> PASS");
        $finish;
    end

endmodule
